//--- design/nccPixelPkg.sv
`default_nettype none

package nccPixelPkg;

	// width of one signed image pixel
	localparam int pixelW = 9;

	// pixels carried by one descriptor transfer
	localparam int pixelsPerWord = 2;

	// the exact dot product of 9-bit pixels fits well inside this
	localparam int scoreW = 32;

	// window number within one frame
	localparam int windowIndexW = 9;

	typedef logic signed [pixelW-1:0] pixelT;

	// first pixel of the pair sits in the upper half
	typedef logic [pixelsPerWord*pixelW-1:0] descWordT;

	typedef logic signed [scoreW-1:0] scoreT;

	typedef logic [windowIndexW-1:0] windowIndexT;

	// pointer width for a counter over n positions, never below one bit
	function automatic int ptrWidth(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

endpackage

`default_nettype wire

//--- design/nccCtrlPkg.sv
`default_nettype none

package nccCtrlPkg;

	// descriptor side, LOAD marks the cycle after an accepted word
	typedef enum logic {
		DESC_WAIT = 1'b0,
		DESC_LOAD = 1'b1
	} descStateT;

	// window side, LOAD lasts one cycle and scores the registered window
	typedef enum logic {
		WIN_WAIT = 1'b0,
		WIN_LOAD = 1'b1
	} winStateT;

endpackage

`default_nettype wire

//--- design/descWriteIf.sv
`timescale 1ns/1ps
`default_nettype none

interface descWriteIf
	import nccPixelPkg::*;
#(
	parameter int patchDim = 4
) ();

	localparam int rowW = ptrWidth(patchDim);
	localparam int colW = ptrWidth(patchDim / pixelsPerWord);

	// one write per cycle with write high, no back-pressure
	logic write;
	logic [rowW-1:0] row;
	logic [colW-1:0] colGroup;
	descWordT word;

	modport ctrl (output write, row, colGroup, word);

	modport store (input write, row, colGroup, word);

endinterface

`default_nettype wire

//--- design/matchController.sv
`timescale 1ns/1ps
`default_nettype none

module matchController
	import nccPixelPkg::*;
	import nccCtrlPkg::*;
#(
	parameter int patchDim = 4,
	parameter int windowsPerFrame = 150
) (
	input logic clk,
	input logic rst,
	input logic descReady,
	input descWordT descWord,
	input logic windowReady,
	descWriteIf.ctrl descWr,
	output logic winLoad,
	output logic bestUpdate,
	output windowIndexT windowIndex,
	output logic doneWindow
);

	localparam int colGroups = patchDim / pixelsPerWord;
	localparam int rowW = ptrWidth(patchDim);
	localparam int colW = ptrWidth(colGroups);

	winStateT winState;
	winStateT winNext;
	logic [rowW-1:0] descRow;
	logic [colW-1:0] descCol;
	logic lastCol;
	logic lastRow;
	logic lastWindow;

	// every accepted word goes straight to the store at the current pointer
	assign descWr.write = descReady;
	assign descWr.row = descRow;
	assign descWr.colGroup = descCol;
	assign descWr.word = descWord;

	assign lastCol = descCol == colW'(colGroups - 1);
	assign lastRow = descRow == rowW'(patchDim - 1);

	// column group first, then row, wrapping to the patch origin
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			descRow <= '0;
			descCol <= '0;
		end else if (descReady) begin
			if (lastCol) begin
				descCol <= '0;
				descRow <= lastRow ? '0 : descRow + 1'b1;
			end else begin
				descCol <= descCol + 1'b1;
			end
		end
	end

	// window flow
	always_comb begin
		winLoad = 1'b0;
		bestUpdate = 1'b0;
		doneWindow = 1'b0;
		winNext = winState;
		case (winState)
			WIN_WAIT: begin
				if (windowReady) begin
					winLoad = 1'b1;
					winNext = WIN_LOAD;
				end
			end
			WIN_LOAD: begin
				// windowReady is not looked at here
				doneWindow = 1'b1;
				bestUpdate = 1'b1;
				winNext = WIN_WAIT;
			end
			default: winNext = WIN_WAIT;
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			winState <= WIN_WAIT;
		end else begin
			winState <= winNext;
		end
	end

	assign lastWindow = windowIndex == windowIndexT'(windowsPerFrame - 1);

	// advances on the same edge the tracker samples, so it sees the old index
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			windowIndex <= '0;
		end else if (bestUpdate) begin
			windowIndex <= lastWindow ? '0 : windowIndex + 1'b1;
		end
	end

	// the source must see a gap before its next window is taken
	doneSingleCycle: assert property (
		@(posedge clk) disable iff (rst) doneWindow |=> !doneWindow
	) else $error("doneWindow high on two consecutive cycles");

	indexInFrame: assert property (
		@(posedge clk) disable iff (rst) windowIndex < windowsPerFrame
	) else $error("windowIndex %0d outside the frame", windowIndex);

endmodule

`default_nettype wire

//--- design/descriptorStore.sv
`timescale 1ns/1ps
`default_nettype none

module descriptorStore
	import nccPixelPkg::*;
#(
	parameter int patchDim = 4
) (
	input logic clk,
	input logic rst,
	descWriteIf.store descWr,
	output pixelT [patchDim-1:0][patchDim-1:0] descPixels
);

	localparam int colGroups = patchDim / pixelsPerWord;

	logic [patchDim-1:0] rowEn;
	logic [colGroups-1:0] groupEn;
	pixelT [pixelsPerWord-1:0] wordPixels;

	// one-hot row and column-group decoders
	assign rowEn = {{(patchDim - 1){1'b0}}, 1'b1} << descWr.row;
	assign groupEn = {{(colGroups - 1){1'b0}}, 1'b1} << descWr.colGroup;

	// highest slot holds the first pixel of the pair
	assign wordPixels = descWr.word;

	for (genvar r = 0; r < patchDim; r++) begin : gRow
		for (genvar g = 0; g < colGroups; g++) begin : gGroup
			always_ff @(posedge clk) begin
				if (descWr.write && rowEn[r] && groupEn[g]) begin
					for (int p = 0; p < pixelsPerWord; p++) begin
						descPixels[r][g*pixelsPerWord + p] <=
							wordPixels[pixelsPerWord - 1 - p];
					end
				end
			end
		end
	end

	// the controller pointer must stay inside the patch
	writeInPatch: assert property (
		@(posedge clk) disable iff (rst)
		descWr.write |-> (descWr.row < patchDim) && (descWr.colGroup < colGroups)
	) else $error("descriptor write outside the patch, row %0d group %0d",
		descWr.row, descWr.colGroup);

endmodule

`default_nettype wire

//--- design/correlationArray.sv
`timescale 1ns/1ps
`default_nettype none

module correlationArray
	import nccPixelPkg::*;
#(
	parameter int patchDim = 4
) (
	input logic clk,
	input logic rst,
	input logic winLoad,
	input pixelT [patchDim-1:0][patchDim-1:0] windowPixels,
	input pixelT [patchDim-1:0][patchDim-1:0] descPixels,
	output scoreT patchScore
);

	pixelT [patchDim-1:0][patchDim-1:0] winReg;
	scoreT rowChain [patchDim][patchDim];
	scoreT rowTotal [patchDim];

	// window held while it is scored
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			winReg <= '0;
		end else if (winLoad) begin
			winReg <= windowPixels;
		end
	end

	// products accumulate left to right along each row
	for (genvar r = 0; r < patchDim; r++) begin : gRow
		for (genvar c = 0; c < patchDim; c++) begin : gCol
			scoreT product;

			assign product = scoreT'(signed'(descPixels[r][c]))
				* scoreT'(signed'(winReg[r][c]));

			if (c == 0) begin : gFirst
				assign rowChain[r][c] = product;
			end else begin : gNext
				assign rowChain[r][c] = rowChain[r][c-1] + product;
			end
		end

		assign rowTotal[r] = rowChain[r][patchDim-1];
	end

	// correlation numerator over the whole patch
	always_comb begin
		patchScore = '0;
		for (int r = 0; r < patchDim; r++) begin
			patchScore = patchScore + rowTotal[r];
		end
	end

endmodule

`default_nettype wire

//--- design/bestMatchTracker.sv
`timescale 1ns/1ps
`default_nettype none

module bestMatchTracker
	import nccPixelPkg::*;
(
	input logic clk,
	input logic rst,
	input logic bestUpdate,
	input scoreT patchScore,
	input windowIndexT windowIndex,
	output scoreT bestScore,
	output windowIndexT bestIndex
);

	logic better;

	// strictly greater, so a tie keeps the earlier window
	assign better = patchScore > bestScore;

	// kept across frame boundaries, only reset clears it
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			bestScore <= '0;
			bestIndex <= '0;
		end else if (bestUpdate && better) begin
			bestScore <= patchScore;
			bestIndex <= windowIndex;
		end
	end

endmodule

`default_nettype wire

//--- design/nccTop.sv
`timescale 1ns/1ps
`default_nettype none

module nccTop
	import nccPixelPkg::*;
#(
	parameter int patchDim = 4,
	parameter int windowsPerFrame = 150
) (
	input logic clk,
	input logic rst,
	input logic descReady,
	input descWordT descWord,
	input logic windowReady,
	input pixelT [patchDim-1:0][patchDim-1:0] windowPixels,
	output logic doneWindow,
	output scoreT bestScore,
	output windowIndexT bestIndex
);

	logic winLoad;
	logic bestUpdate;
	windowIndexT windowIndex;
	scoreT patchScore;
	pixelT [patchDim-1:0][patchDim-1:0] descPixels;

	descWriteIf #(.patchDim(patchDim)) descWr ();

	matchController #(
		.patchDim(patchDim),
		.windowsPerFrame(windowsPerFrame)
	) i_matchController (
		.clk(clk),
		.rst(rst),
		.descReady(descReady),
		.descWord(descWord),
		.windowReady(windowReady),
		.descWr(descWr.ctrl),
		.winLoad(winLoad),
		.bestUpdate(bestUpdate),
		.windowIndex(windowIndex),
		.doneWindow(doneWindow)
	);

	descriptorStore #(.patchDim(patchDim)) i_descriptorStore (
		.clk(clk),
		.rst(rst),
		.descWr(descWr.store),
		.descPixels(descPixels)
	);

	correlationArray #(.patchDim(patchDim)) i_correlationArray (
		.clk(clk),
		.rst(rst),
		.winLoad(winLoad),
		.windowPixels(windowPixels),
		.descPixels(descPixels),
		.patchScore(patchScore)
	);

	bestMatchTracker i_bestMatchTracker (
		.clk(clk),
		.rst(rst),
		.bestUpdate(bestUpdate),
		.patchScore(patchScore),
		.windowIndex(windowIndex),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

endmodule

`default_nettype wire

//--- tests/nccTb.sv
`timescale 1ns/1ps
`default_nettype none

module nccTb
	import nccPixelPkg::*;
();

	localparam int patchDim = 4;
	localparam int windowsPerFrame = 6;
	localparam int groups = patchDim / pixelsPerWord;
	localparam int wordsPerPatch = patchDim * groups;
	// reset, then the six tests in order
	localparam int testCycles = 10 + 23 + 16 + 18 + 24 + 12 + 24;
	localparam int cycleLimit = 2 * testCycles + 100;

	typedef pixelT [patchDim-1:0][patchDim-1:0] patchT;

	logic clk;
	logic rst;
	logic descReady;
	descWordT descWord;
	logic windowReady;
	patchT windowPixels;
	logic doneWindow;
	scoreT bestScore;
	windowIndexT bestIndex;

	// reference model state
	pixelT modelDesc [patchDim][patchDim];
	int ptrRow = 0;
	int ptrGroup = 0;
	scoreT expScore = '0;
	windowIndexT expIndex = '0;
	windowIndexT frameIndex = '0;
	bit started = 1'b0;

	integer seed = 45;
	int errorCount = 0;
	int testStartErrors = 0;
	int testNum = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int cycleCount = 0;

	nccTop #(
		.patchDim(patchDim),
		.windowsPerFrame(windowsPerFrame)
	) i_nccTop (
		.clk(clk),
		.rst(rst),
		.descReady(descReady),
		.descWord(descWord),
		.windowReady(windowReady),
		.windowPixels(windowPixels),
		.doneWindow(doneWindow),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycleCount);
			$display("TEST FAILED");
			$finish;
		end
	end

	// nothing changes before the first window
	idleScore: assert property (@(posedge clk) disable iff (rst) !started |-> bestScore == 0)
	else begin
		errorCount++;
		$display("mismatch at %0t: bestScore expected 0, got %0d", $time, $sampled(bestScore));
	end

	idleIndex: assert property (@(posedge clk) disable iff (rst) !started |-> bestIndex == 0)
	else begin
		errorCount++;
		$display("mismatch at %0t: bestIndex expected 0, got %0d", $time, $sampled(bestIndex));
	end

	// handshake timing
	acceptThenDone: assert property (
		@(posedge clk) disable iff (rst) windowReady && !doneWindow |=> doneWindow
	) else begin
		errorCount++;
		$display("at %0t a window was offered while idle but doneWindow did not follow", $time);
	end

	doneOneCycle: assert property (@(posedge clk) disable iff (rst) doneWindow |=> !doneWindow)
	else begin
		errorCount++;
		$display("at %0t doneWindow stayed high for more than one cycle", $time);
	end

	noSpuriousDone: assert property (
		@(posedge clk) disable iff (rst) !doneWindow && !windowReady |=> !doneWindow
	) else begin
		errorCount++;
		$display("at %0t doneWindow rose although no window was offered", $time);
	end

	// result of each window, one cycle after doneWindow
	bestScoreAfterDone: assert property (
		@(posedge clk) disable iff (rst) doneWindow |=> bestScore == expScore
	) else begin
		errorCount++;
		$display("mismatch at %0t: bestScore expected %0d, got %0d",
			$time, expScore, $sampled(bestScore));
	end

	bestIndexAfterDone: assert property (
		@(posedge clk) disable iff (rst) doneWindow |=> bestIndex == expIndex
	) else begin
		errorCount++;
		$display("mismatch at %0t: bestIndex expected %0d, got %0d",
			$time, expIndex, $sampled(bestIndex));
	end

	function automatic scoreT dotProduct(input patchT win);
		int acc;
		acc = 0;
		for (int r = 0; r < patchDim; r++) begin
			for (int c = 0; c < patchDim; c++) begin
				acc += int'(modelDesc[r][c]) * int'(win[r][c]);
			end
		end
		return scoreT'(acc);
	endfunction

	// score is scale times the descriptor energy
	function automatic patchT scaledWindow(input int scale);
		patchT w;
		for (int r = 0; r < patchDim; r++) begin
			for (int c = 0; c < patchDim; c++) begin
				w[r][c] = pixelT'(scale * int'(modelDesc[r][c]));
			end
		end
		return w;
	endfunction

	// full-scale pixels with the descriptor's signs
	function automatic patchT signWindow();
		patchT w;
		for (int r = 0; r < patchDim; r++) begin
			for (int c = 0; c < patchDim; c++) begin
				w[r][c] = (modelDesc[r][c] < 0) ? pixelT'(-256) : pixelT'(255);
			end
		end
		return w;
	endfunction

	function automatic patchT randomWindow();
		patchT w;
		for (int r = 0; r < patchDim; r++) begin
			for (int c = 0; c < patchDim; c++) begin
				w[r][c] = pixelT'($random(seed));
			end
		end
		return w;
	endfunction

	// strictly greater signed score wins, index wraps per frame
	task automatic modelWindow(input patchT win);
		scoreT s;
		s = dotProduct(win);
		if (s > expScore) begin
			expScore = s;
			expIndex = frameIndex;
		end
		frameIndex = (frameIndex == windowIndexT'(windowsPerFrame - 1)) ? '0 : frameIndex + 1'b1;
	endtask

	// wide selects full 9-bit pixels, else a small range
	task automatic loadDescriptor(input bit wide);
		pixelT first;
		pixelT second;
		for (int w = 0; w < wordsPerPatch; w++) begin
			first = wide ? pixelT'($random(seed)) : pixelT'($random(seed) % 64);
			second = wide ? pixelT'($random(seed)) : pixelT'($random(seed) % 64);
			@(posedge clk);
			descReady <= 1'b1;
			descWord <= {first, second};
			modelDesc[ptrRow][ptrGroup * pixelsPerWord] = first;
			modelDesc[ptrRow][ptrGroup * pixelsPerWord + 1] = second;
			if (ptrGroup == groups - 1) begin
				ptrGroup = 0;
				ptrRow = (ptrRow == patchDim - 1) ? 0 : ptrRow + 1;
			end else begin
				ptrGroup++;
			end
		end
		@(posedge clk);
		descReady <= 1'b0;
	endtask

	task automatic offerWindow(input patchT win);
		@(posedge clk);
		started = 1'b1;
		windowReady <= 1'b1;
		windowPixels <= win;
		do @(negedge clk); while (!doneWindow);
		modelWindow(win);
		@(posedge clk);
		windowReady <= 1'b0;
	endtask

	// windowReady held high, junk shown during each doneWindow cycle
	task automatic streamWindows(input int count);
		patchT next;
		patchT junk;
		junk = signWindow();
		next = randomWindow();
		@(posedge clk);
		started = 1'b1;
		windowReady <= 1'b1;
		windowPixels <= next;
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			windowPixels <= junk;
			@(negedge clk);
			if (doneWindow) begin
				modelWindow(next);
			end else begin
				errorCount++;
				$display("window %0d was not accepted while windowReady was held high", i);
			end
			next = randomWindow();
			@(posedge clk);
			if (i == count - 1) begin
				windowReady <= 1'b0;
			end else begin
				windowPixels <= next;
			end
		end
	endtask

	task automatic startTest();
		testStartErrors = errorCount;
	endtask

	// lets the last result check fire before counting
	task automatic endTest(input string name);
		int errs;
		repeat (2) @(posedge clk);
		@(negedge clk);
		errs = errorCount - testStartErrors;
		testNum++;
		if (errs == 0) begin
			testsPassed++;
			$display("test %0d %s: passed", testNum, name);
		end else begin
			testsFailed++;
			$display("test %0d %s: %0d errors", testNum, name, errs);
		end
	endtask

	initial begin
		rst = 1'b1;
		descReady = 1'b0;
		descWord = '0;
		windowReady = 1'b0;
		windowPixels = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		startTest();
		repeat (20) @(posedge clk);
		endTest("idle after reset");

		startTest();
		loadDescriptor(1'b0);
		offerWindow(scaledWindow(1));
		endTest("first window");

		// higher, equal, lower, negative, random
		startTest();
		offerWindow(scaledWindow(2));
		offerWindow(scaledWindow(2));
		offerWindow(scaledWindow(1));
		offerWindow(scaledWindow(-1));
		offerWindow(randomWindow());
		endTest("best score rule");

		// best match at index 3 of the second frame
		startTest();
		offerWindow(scaledWindow(0));
		offerWindow(scaledWindow(-2));
		offerWindow(scaledWindow(1));
		offerWindow(scaledWindow(4));
		offerWindow(randomWindow());
		offerWindow(randomWindow());
		offerWindow(scaledWindow(1));
		endTest("frame wrap");

		startTest();
		streamWindows(4);
		endTest("continuous windowReady");

		startTest();
		loadDescriptor(1'b1);
		offerWindow(scaledWindow(1));
		offerWindow(signWindow());
		offerWindow(scaledWindow(-1));
		offerWindow(randomWindow());
		endTest("descriptor reload");

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			testNum, testsPassed, testsFailed, errorCount);
		if (errorCount == 0 && testsFailed == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
design/nccPixelPkg.sv
design/nccCtrlPkg.sv
design/descWriteIf.sv
design/matchController.sv
design/descriptorStore.sv
design/correlationArray.sv
design/bestMatchTracker.sv
design/nccTop.sv
tests/nccTb.sv
